/* flist.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/mem_bus_pkg.sv
verilog/unified_mem.sv
verilog/mem_arbiter.sv
verilog/prog_loader.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
verif/tb_fetch_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fetch testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_fetch_top -o tb_fetch_top
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_fetch_top 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The run passes only if the testbench printed its pass line
if echo "$sim_output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

/* verif/tb_fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_top
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int MEM_AW = $clog2(`FETCH_MEM_WORDS);
    localparam int PROG_WORDS = 64;
    localparam int BLK_WORDS = 16;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    localparam logic [31:0] BLK_BASE = 32'h0000_0300;
    localparam logic [31:0] HALT_BASE = 32'h0000_0380;
    // Control pulse select bits in the order interrupt, rti, branch, rsi
    localparam logic [3:0] SEL_IRQ = 4'b1000;
    localparam logic [3:0] SEL_RTI = 4'b0100;
    localparam logic [3:0] SEL_BRANCH = 4'b0010;
    localparam logic [3:0] SEL_RSI = 4'b0001;
    // Rough cycles for load and run, gaps, branch, irq, new block and ebreak
    localparam int TEST_LEN_SUM = 768 + 256 + 64 + 128 + 160 + 128;
    localparam int TIMEOUT_CYCLES = 4 * TEST_LEN_SUM;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        branch;
    logic [31:0] branch_target;
    logic        interrupt;
    logic        rti;
    logic        rsi;
    logic        load_valid;
    logic        load_ready;
    load_word_t  load_in;
    logic        out_valid;
    logic        out_ready;
    fetch_pkt_t  out_pkt;
    logic        halted;

    // Stimulus tables filled once at time zero
    logic [31:0] lfsr_q;
    logic [31:0] prog_words [PROG_WORDS];
    logic [31:0] blk_words [BLK_WORDS];
    logic        gap_tab [1024];
    logic [9:0]  gap_idx;
    logic        gaps_on = 1'b0;
    logic [31:0] load_q [$];

    // Reference model state
    logic [31:0] ref_mem [`FETCH_MEM_WORDS];
    logic [31:0] ref_ld_addr;
    logic [31:0] exp_pc;
    logic [31:0] exp_ret;
    logic        exp_halted;
    logic        ld_accepted;
    int          pkt_count = 0;
    int          cycle_count = 0;

    fetch_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .branch        (branch),
        .branch_target (branch_target),
        .interrupt     (interrupt),
        .rti           (rti),
        .rsi           (rsi),
        .load_valid    (load_valid),
        .load_ready    (load_ready),
        .load_in       (load_in),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pkt       (out_pkt),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // Random program word that is sometimes zero and never ebreak
    function automatic logic [31:0] prog_word(input int i);
        logic [31:0] w;
        w = rand_bits(32);
        if (rand_bits(3) == 0 || i % 16 == 5) begin
            w = '0;
        end
        if (w == EBREAK_WORD) begin
            w = w ^ 32'd1;
        end
        return w;
    endfunction

    // Background fill that is never zero or ebreak below 64 KiB
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0] ^ a[31:16], ~a[15:0]};
    endfunction

    // Expected packet for a pc with a zero word shown as NOP
    function automatic fetch_pkt_t ref_packet(input logic [31:0] pc);
        fetch_pkt_t p;
        logic [31:0] w;
        w = ref_mem[pc[MEM_AW+1:2]];
        p.pc_curr = pc;
        p.pc_next = pc + 32'd4;
        p.instr = (w == 32'd0) ? `FETCH_NOP : w;
        return p;
    endfunction

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        stop_run();
    endtask

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp);
        if (got.pc_curr !== exp.pc_curr) begin
            report_mismatch("out_pkt.pc_curr", got.pc_curr, exp.pc_curr);
        end
        if (got.pc_next !== exp.pc_next) begin
            report_mismatch("out_pkt.pc_next", got.pc_next, exp.pc_next);
        end
        if (got.instr !== exp.instr) begin
            report_mismatch("out_pkt.instr", got.instr, exp.instr);
        end
    endtask

    task automatic check_halted(input logic got);
        if (got !== exp_halted) begin
            $display("[FAIL] halted got 0x%0h expected 0x%0h", got, exp_halted);
            stop_run();
        end
    endtask

    task automatic check_load_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] load_ready got 0x%0h expected 0x%0h", got, exp);
            stop_run();
        end
    endtask

    // Reference model and compare on pre-edge values
    always @(posedge clk) begin : ref_model
        fetch_pkt_t  exp_pkt;
        logic [31:0] ld_a;
        logic [31:0] ret_old;
        if (!rst_n) begin
            exp_pc = `FETCH_RESET_PC;
            exp_ret = '0;
            exp_halted = 1'b0;
            ref_ld_addr = '0;
            ld_accepted = 1'b0;
        end else begin
            check_halted(halted);
            // Loader holds the accepted word as a pending write
            if (ld_accepted) begin
                check_load_ready(load_ready, 1'b0);
            end
            ld_accepted = load_valid && load_ready;
            // Same auto-increment rule as the load stream
            if (load_valid && load_ready) begin
                ld_a = load_in.first ? load_in.addr : ref_ld_addr;
                ref_mem[ld_a[MEM_AW+1:2]] = load_in.data;
                ref_ld_addr = ld_a + 32'd4;
            end
            // Transfer in a redirect cycle counts first
            if (out_valid && out_ready) begin
                if (exp_halted) begin
                    $display("A packet was delivered while fetch was halted");
                    stop_run();
                end
                exp_pkt = ref_packet(exp_pc);
                check_pkt(out_pkt, exp_pkt);
                pkt_count <= pkt_count + 1;
                if (exp_pkt.instr == EBREAK_WORD) begin
                    exp_halted = 1'b1;
                end
                exp_pc = exp_pc + 32'd4;
            end
            // Saved address is the oldest undelivered pc
            ret_old = exp_ret;
            if (interrupt) begin
                exp_ret = exp_pc;
            end else if (rsi) begin
                exp_ret = '0;
            end
            if (interrupt) begin
                exp_pc = `FETCH_IRQ_VECTOR;
            end else if (rti) begin
                exp_pc = ret_old;
            end else if (branch) begin
                exp_pc = branch_target;
            end
            if (interrupt || rti || branch) begin
                exp_halted = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // Decode back-pressure with about one cycle in four low
    initial begin
        out_ready <= 1'b0;
        gap_idx = '0;
        forever begin
            @(posedge clk);
            out_ready <= gaps_on ? gap_tab[gap_idx] : 1'b1;
            gap_idx = gap_idx + 10'd1;
        end
    end

    // Drains load_q into the loader and opens the block at base
    task automatic load_block(input logic [31:0] base);
        int n;
        logic [31:0] w;
        n = 0;
        while (load_q.size() > 0) begin
            w = load_q.pop_front();
            load_valid <= 1'b1;
            load_in <= '{first: (n == 0), addr: (n == 0) ? base : 32'h0, data: w};
            n++;
            @(posedge clk);
            while (!load_ready) @(posedge clk);
        end
        load_valid <= 1'b0;
    endtask

    // Returns once the last pending write has been granted
    task automatic drain_loader();
        @(posedge clk);
        while (!load_ready) @(posedge clk);
    endtask

    task automatic pulse_ctrl(input logic [3:0] sel, input logic [31:0] target);
        {interrupt, rti, branch, rsi} <= sel;
        branch_target <= target;
        @(posedge clk);
        {interrupt, rti, branch, rsi} <= 4'b0000;
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = pkt_count + n;
        while (pkt_count < target) @(posedge clk);
    endtask

    initial begin
        lfsr_q = 32'hcc27_5537;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_words[i] = prog_word(i);
        end
        for (int i = 0; i < BLK_WORDS; i++) begin
            blk_words[i] = prog_word(i);
        end
        for (int i = 0; i < 1024; i++) begin
            gap_tab[i] = (rand_bits(2) != 0);
        end
        rst_n <= 1'b0;
        run <= 1'b0;
        {interrupt, rti, branch, rsi} <= 4'b0000;
        branch_target <= '0;
        load_valid <= 1'b0;
        load_in <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Whole memory loaded with the random program at 0 and address fill above
        for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
            load_q.push_back(i < PROG_WORDS ? prog_words[i] : fill_word(32'(i * 4)));
        end
        load_block(32'h0);
        @(posedge clk);
        run <= 1'b1;
        wait_packets(PROG_WORDS);

        // Random stalls from decode
        gaps_on <= 1'b1;
        wait_packets(64);

        pulse_ctrl(SEL_BRANCH, 32'h0000_0040);
        wait_packets(8);

        // Interrupt and return followed by a cleared return register
        pulse_ctrl(SEL_IRQ, '0);
        wait_packets(4);
        pulse_ctrl(SEL_RTI, '0);
        wait_packets(4);
        pulse_ctrl(SEL_IRQ, '0);
        wait_packets(3);
        pulse_ctrl(SEL_RSI, '0);
        wait_packets(2);
        pulse_ctrl(SEL_RTI, '0);
        wait_packets(4);

        // New block while fetch runs far below it
        pulse_ctrl(SEL_BRANCH, 32'h0);
        for (int i = 0; i < BLK_WORDS; i++) begin
            load_q.push_back(blk_words[i]);
        end
        load_block(BLK_BASE);
        drain_loader();
        pulse_ctrl(SEL_BRANCH, BLK_BASE);
        wait_packets(BLK_WORDS);

        // Three words then ebreak
        pulse_ctrl(SEL_BRANCH, 32'h0);
        for (int i = 0; i < 3; i++) begin
            load_q.push_back(fill_word(HALT_BASE + 32'(i * 4)));
        end
        load_q.push_back(EBREAK_WORD);
        load_block(HALT_BASE);
        drain_loader();
        pulse_ctrl(SEL_BRANCH, HALT_BASE);
        while (!halted) @(posedge clk);
        // Checker flags any packet while halted
        repeat (50) @(posedge clk);
        pulse_ctrl(SEL_BRANCH, 32'h0000_0020);
        wait_packets(4);
        repeat (4) @(posedge clk);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic        branch,
    input  logic [31:0] branch_target,
    input  logic        interrupt,
    input  logic        rti,
    input  logic        rsi,
    input  logic        load_valid,
    output logic        load_ready,
    input  load_word_t  load_in,
    output logic        out_valid,
    input  logic        out_ready,
    output fetch_pkt_t  out_pkt,
    output logic        halted
);

    // Loader to arbiter
    logic     ld_req_valid;
    logic     ld_req_ready;
    mem_req_t ld_req;
    // Fetch to arbiter
    logic     fe_req_valid;
    logic     fe_req_ready;
    mem_req_t fe_req;
    logic     fe_rsp_valid;
    mem_rsp_t fe_rsp;
    // Arbiter to memory
    logic     mem_en;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    prog_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_in    (load_in),
        .req_valid  (ld_req_valid),
        .req_ready  (ld_req_ready),
        .req        (ld_req)
    );

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .branch        (branch),
        .branch_target (branch_target),
        .interrupt     (interrupt),
        .rti           (rti),
        .rsi           (rsi),
        .req_valid     (fe_req_valid),
        .req_ready     (fe_req_ready),
        .req           (fe_req),
        .rsp_valid     (fe_rsp_valid),
        .rsp           (fe_rsp),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pkt       (out_pkt),
        .halted        (halted)
    );

    mem_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_req_valid (ld_req_valid),
        .ld_req_ready (ld_req_ready),
        .ld_req       (ld_req),
        .fe_req_valid (fe_req_valid),
        .fe_req_ready (fe_req_ready),
        .fe_req       (fe_req),
        .fe_rsp_valid (fe_rsp_valid),
        .fe_rsp       (fe_rsp),
        .mem_en       (mem_en),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    unified_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (mem_en),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_unit
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic        branch,
    input  logic [31:0] branch_target,
    input  logic        interrupt,
    input  logic        rti,
    input  logic        rsi,
    // Memory request side
    output logic        req_valid,
    input  logic        req_ready,
    output mem_req_t    req,
    input  logic        rsp_valid,
    input  mem_rsp_t    rsp,
    // Packet stream to decode
    output logic        out_valid,
    input  logic        out_ready,
    output fetch_pkt_t  out_pkt,
    output logic        halted
);

    // Next address to fetch
    logic [31:0] pc_q;
    // Saved return address for rti
    logic [31:0] ret_q;
    // Outstanding read, its pc and the epoch it was issued in
    logic        os_q;
    logic [31:0] os_pc_q;
    logic        os_epoch_q;
    // Flips on every redirect
    logic        epoch_q;
    logic        epoch_nxt;
    // Output register
    logic        out_valid_q;
    fetch_pkt_t  out_pkt_q;
    logic        halted_q;

    logic        redirect;
    logic [31:0] redir_pc;
    logic [31:0] oldest_pc;
    logic        req_fire;
    logic        out_fire;
    logic        rsp_ok;
    logic        out_ebrk;
    instr_t      rsp_word;
    instr_t      out_word;
    logic [31:0] instr_fix;

    // Any redirect pulse acts as the flush
    assign redirect  = interrupt || rti || branch;
    assign epoch_nxt = epoch_q ^ redirect;

    // Redirect priority, interrupt first
    always_comb begin
        if (interrupt) begin
            redir_pc = `FETCH_IRQ_VECTOR;
        end else if (rti) begin
            redir_pc = ret_q;
        end else begin
            redir_pc = branch_target;
        end
    end

    assign out_fire = out_valid_q && out_ready;
    assign out_word = out_pkt_q.instr;
    assign out_ebrk = out_valid_q && is_ebreak(out_word);

    // Issue only with nothing outstanding and room in the output register
    // Stop behind a pending ebreak so nothing follows it
    assign req_valid = run && !halted_q && !os_q && !out_ebrk &&
                       (!out_valid_q || out_ready);
    assign req_fire  = req_valid && req_ready;
    assign req       = '{we: 1'b0, addr: pc_q, wdata: 32'd0};

    // Compare against the epoch after this edge
    // Responses in or after a redirect cycle are dropped
    assign rsp_ok = rsp_valid && os_q && (os_epoch_q == epoch_nxt);

    // All-zero word becomes the canonical NOP
    assign rsp_word  = rsp.rdata;
    assign instr_fix = (rsp_word.raw == 32'd0) ? `FETCH_NOP : rsp_word.raw;

    // Oldest instruction not yet handed to decode
    always_comb begin
        if (out_valid_q && !out_ready) begin
            oldest_pc = out_pkt_q.pc_curr;
        end else if (os_q && (os_epoch_q == epoch_q)) begin
            oldest_pc = os_pc_q;
        end else begin
            oldest_pc = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q        <= `FETCH_RESET_PC;
            ret_q       <= '0;
            os_q        <= 1'b0;
            epoch_q     <= 1'b0;
            out_valid_q <= 1'b0;
            halted_q    <= 1'b0;
        end else begin
            epoch_q <= epoch_nxt;

            // Redirect wins over sequential advance
            if (redirect) begin
                pc_q <= redir_pc;
            end else if (req_fire) begin
                pc_q <= pc_q + 32'd4;
            end

            if (req_fire) begin
                os_q <= 1'b1;
            end else if (rsp_valid) begin
                os_q <= 1'b0;
            end

            // Packet sent this cycle still counts before the flush
            if (redirect) begin
                out_valid_q <= 1'b0;
            end else if (rsp_ok) begin
                out_valid_q <= 1'b1;
            end else if (out_fire) begin
                out_valid_q <= 1'b0;
            end

            if (redirect) begin
                halted_q <= 1'b0;
            end else if (out_fire && out_ebrk) begin
                halted_q <= 1'b1;
            end

            // interrupt beats a simultaneous rsi
            if (interrupt) begin
                ret_q <= oldest_pc;
            end else if (rsi) begin
                ret_q <= '0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (req_fire) begin
            os_pc_q    <= pc_q;
            os_epoch_q <= epoch_q;
        end
        if (rsp_ok) begin
            out_pkt_q <= '{pc_curr: os_pc_q, pc_next: os_pc_q + 32'd4, instr: instr_fix};
        end
    end

    assign out_valid = out_valid_q;
    assign out_pkt   = out_pkt_q;
    assign halted    = halted_q;

endmodule

`default_nettype wire

/* verilog/prog_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module prog_loader
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_valid,
    output logic       load_ready,
    input  load_word_t load_in,
    output logic       req_valid,
    input  logic       req_ready,
    output mem_req_t   req
);

    logic        pend_q;
    mem_req_t    pend_req_q;
    logic [31:0] addr_q;
    logic [31:0] addr_use;
    logic        accept;

    // One write in flight at most
    assign load_ready = !pend_q;
    assign accept     = load_valid && load_ready;

    // New block restarts the counter
    assign addr_use = load_in.first ? load_in.addr : addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            addr_q <= '0;
        end else if (accept) begin
            pend_q <= 1'b1;
            addr_q <= addr_use + 32'd4;
        end else if (req_ready) begin
            // Grant retires the write
            pend_q <= 1'b0;
        end
    end

    // Write payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_req_q <= '{we: 1'b1, addr: addr_use, wdata: load_in.data};
        end
    end

    assign req_valid = pend_q;
    assign req       = pend_req_q;

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Loader port, writes only
    input  logic     ld_req_valid,
    output logic     ld_req_ready,
    input  mem_req_t ld_req,
    // Fetch port, reads only
    input  logic     fe_req_valid,
    output logic     fe_req_ready,
    input  mem_req_t fe_req,
    output logic     fe_rsp_valid,
    output mem_rsp_t fe_rsp,
    // Memory side
    output logic     mem_en,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // Set when fetch won the last granted cycle
    logic last_fe_q;
    // Fetch read granted last cycle, data due now
    logic fe_rd_q;

    // Tie goes to whoever did not win last
    // A lone requester wins at once
    assign ld_req_ready = ld_req_valid && (!fe_req_valid || last_fe_q);
    assign fe_req_ready = fe_req_valid && (!ld_req_valid || !last_fe_q);

    assign mem_en  = ld_req_ready || fe_req_ready;
    assign mem_req = fe_req_ready ? fe_req : ld_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_fe_q <= 1'b0;
            fe_rd_q   <= 1'b0;
        end else begin
            // Only a real grant moves the round-robin pointer
            if (fe_req_ready) begin
                last_fe_q <= 1'b1;
            end else if (ld_req_ready) begin
                last_fe_q <= 1'b0;
            end
            fe_rd_q <= fe_req_ready && !fe_req.we;
        end
    end

    // Memory has one cycle read latency, so data lines up with the flag
    assign fe_rsp_valid = fe_rd_q;
    assign fe_rsp       = mem_rsp;

endmodule

`default_nettype wire

/* verilog/unified_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_cfg.svh"

module unified_mem
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    localparam int unsigned AW = $clog2(`FETCH_MEM_WORDS);

    // Word storage, no reset
    logic [31:0] mem_q [`FETCH_MEM_WORDS];
    logic [31:0] rdata_q;
    logic [AW-1:0] word_idx;

    // Byte address to word index, low two bits dropped
    assign word_idx = req.addr[AW+1:2];

    // Write lands at the enable edge
    always_ff @(posedge clk) begin
        if (en && req.we) begin
            mem_q[word_idx] <= req.wdata;
        end
    end

    // Read data valid the cycle after the enable cycle
    // Held between reads
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (en && !req.we) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Request into the shared memory
    // Byte address, always word aligned
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Read data back from the memory
    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

    // One word of the program load stream
    // first set starts a new block at addr
    // Otherwise addr is ignored and the loader auto-increments
    typedef struct packed {
        logic        first;
        logic [31:0] addr;
        logic [31:0] data;
    } load_word_t;

endpackage

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcode of the SYSTEM group (ecall, ebreak, csr ops)
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    // I-type field layout, msb first
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // One instruction word, seen as raw bits or as I-type fields
    typedef union packed {
        logic [31:0] raw;
        i_fields_t   i;
    } instr_t;

    // Packet handed to decode
    typedef struct packed {
        logic [31:0] pc_curr;
        logic [31:0] pc_next;
        logic [31:0] instr;
    } fetch_pkt_t;

    // ebreak is SYSTEM with imm 1 and every other field zero
    function automatic logic is_ebreak(instr_t w);
        return (w.i.opcode == OPC_SYSTEM) && (w.i.imm == 12'd1) &&
               (w.i.rs1 == 5'd0) && (w.i.funct3 == 3'd0) && (w.i.rd == 5'd0);
    endfunction

endpackage

`default_nettype wire

/* verilog/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Depth of the shared instruction and program memory, in 32-bit words
`define FETCH_MEM_WORDS 256

// Byte address fetched first after reset
`define FETCH_RESET_PC 32'h0000_0000

// Byte address of the interrupt handler entry
`define FETCH_IRQ_VECTOR 32'h0000_0004

// Canonical NOP is addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif
